// ==== flist.f ====
+incdir+src
src/rvv_pkg.sv
src/rvv_alu_dispatch.sv
src/rvv_alu_rs.sv
src/rvv_alu_unit.sv
src/rvv_rob.sv
src/rvv_alu_top.sv
verification/tb_rvv_alu_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mask-logic testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module tb_rvv_alu_top \
  -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

// ==== src/rvv_alu_dispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_settings.svh"

module rvv_alu_dispatch
  import rvv_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     uop_valid,
  input  opm_funct_e               uop_funct,
  input  logic [`VSTART_WIDTH-1:0] uop_vstart,
  input  logic [`VLEN-1:0]         uop_vd,
  input  logic [`VLEN-1:0]         uop_vs1,
  input  logic [`VLEN-1:0]         uop_vs2,
  input  logic                     retire_valid,
  output logic                     dispatch_stall,
  output logic                     rs_push_valid,
  output alu_rs_t                  rs_push_uop
);

  localparam int CNT_W = `ROB_DEPTH_WIDTH + 1;

  logic [`ROB_DEPTH_WIDTH-1:0] next_tag;
  logic [CNT_W-1:0]            inflight_cnt;
  logic                        accept;

  assign accept = uop_valid & ~dispatch_stall;

  // every ROB entry is owned by a uop somewhere in the pipe
  assign dispatch_stall = (inflight_cnt == CNT_W'(`ROB_DEPTH));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      next_tag      <= '0;
      inflight_cnt  <= '0;
      rs_push_valid <= 1'b0;
    end else begin
      rs_push_valid <= accept;
      if (accept) begin
        next_tag <= next_tag + 1'b1;
      end
      // up on accept, down on retire, both at once leaves it alone
      if (accept && !retire_valid) begin
        inflight_cnt <= inflight_cnt + 1'b1;
      end else if (!accept && retire_valid) begin
        inflight_cnt <= inflight_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rs_push_uop.rob_entry <= next_tag;
      rs_push_uop.uop_funct <= uop_funct;
      rs_push_uop.vstart    <= uop_vstart;
      rs_push_uop.vd_data   <= uop_vd;
      rs_push_uop.vs1_data  <= uop_vs1;
      rs_push_uop.vs2_data  <= uop_vs2;
    end
  end

  // source has to hold off while stalled
  a_no_uop_in_stall: assert property (
    @(posedge clk) disable iff (!arst_n) dispatch_stall |-> !uop_valid
  ) else $error("uop_valid high while dispatch_stall, funct=%s", uop_funct.name());

endmodule

`default_nettype wire

// ==== src/rvv_alu_rs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_settings.svh"

module rvv_alu_rs
  import rvv_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    push_valid,
  input  alu_rs_t push_uop,
  output logic    alu_uop_valid,
  output alu_rs_t alu_uop
);

  localparam int PTR_W = $clog2(`RS_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`RS_DEPTH - 1);

  alu_rs_t          entries [`RS_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             pop;

  // oldest entry goes out whenever there is one
  assign alu_uop_valid = (count != '0);
  assign alu_uop       = entries[rd_ptr];
  assign pop           = alu_uop_valid;
  assign full          = (count == CNT_W'(`RS_DEPTH));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_valid) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      if (push_valid && !pop) begin
        count <= count + 1'b1;
      end else if (!push_valid && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_valid) begin
      entries[wr_ptr] <= push_uop;
    end
  end

  // dispatch stall keeps occupancy within ROB depth
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!arst_n) push_valid |-> !full
  ) else $error("push into full RS, rob_entry=%0d", push_uop.rob_entry);

endmodule

`default_nettype wire

// ==== src/rvv_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_settings.svh"

module rvv_alu_top
  import rvv_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        uop_valid,
  input  opm_funct_e                  uop_funct,
  input  logic [`VSTART_WIDTH-1:0]    uop_vstart,
  input  logic [`VLEN-1:0]            uop_vd,
  input  logic [`VLEN-1:0]            uop_vs1,
  input  logic [`VLEN-1:0]            uop_vs2,
  input  logic                        commit_en,
  output logic                        dispatch_stall,
  output logic                        retire_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0] retire_rob_entry,
  output logic [`VLEN-1:0]            retire_data
);

  logic     rs_push_valid;
  alu_rs_t  rs_push_uop;
  logic     alu_uop_valid;
  alu_rs_t  alu_uop;
  logic     result_valid;
  alu2rob_t result;

  rvv_alu_dispatch rvv_alu_dispatch_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .uop_valid      (uop_valid),
    .uop_funct      (uop_funct),
    .uop_vstart     (uop_vstart),
    .uop_vd         (uop_vd),
    .uop_vs1        (uop_vs1),
    .uop_vs2        (uop_vs2),
    .retire_valid   (retire_valid),
    .dispatch_stall (dispatch_stall),
    .rs_push_valid  (rs_push_valid),
    .rs_push_uop    (rs_push_uop)
  );

  rvv_alu_rs rvv_alu_rs_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .push_valid    (rs_push_valid),
    .push_uop      (rs_push_uop),
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop)
  );

  rvv_alu_unit rvv_alu_unit_i (
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop),
    .result_valid  (result_valid),
    .result        (result)
  );

  // retire pulse also frees an in-flight slot in dispatch
  rvv_rob rvv_rob_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .result_valid     (result_valid),
    .result           (result),
    .commit_en        (commit_en),
    .retire_valid     (retire_valid),
    .retire_rob_entry (retire_rob_entry),
    .retire_data      (retire_data)
  );

endmodule

`default_nettype wire

// ==== src/rvv_alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_settings.svh"

module rvv_alu_unit
  import rvv_pkg::*;
(
  input  logic     alu_uop_valid,
  input  alu_rs_t  alu_uop,
  output logic     result_valid,
  output alu2rob_t result
);

  logic [`VLEN-1:0] logic_result;
  logic [`VLEN-1:0] w_data;

  function automatic logic [`VLEN-1:0] f_vmandn(input logic [`VLEN-1:0] vs2,
                                                input logic [`VLEN-1:0] vs1);
    return vs2 & ~vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmand(input logic [`VLEN-1:0] vs2,
                                               input logic [`VLEN-1:0] vs1);
    return vs2 & vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmor(input logic [`VLEN-1:0] vs2,
                                              input logic [`VLEN-1:0] vs1);
    return vs2 | vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmxor(input logic [`VLEN-1:0] vs2,
                                               input logic [`VLEN-1:0] vs1);
    return vs2 ^ vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmorn(input logic [`VLEN-1:0] vs2,
                                               input logic [`VLEN-1:0] vs1);
    return vs2 | ~vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmnand(input logic [`VLEN-1:0] vs2,
                                                input logic [`VLEN-1:0] vs1);
    return ~(vs2 & vs1);
  endfunction

  function automatic logic [`VLEN-1:0] f_vmnor(input logic [`VLEN-1:0] vs2,
                                               input logic [`VLEN-1:0] vs1);
    return ~(vs2 | vs1);
  endfunction

  function automatic logic [`VLEN-1:0] f_vmxnor(input logic [`VLEN-1:0] vs2,
                                                input logic [`VLEN-1:0] vs1);
    return ~(vs2 ^ vs1);
  endfunction

  // opcode decode
  always_comb begin
    logic_result = '0;
    case (alu_uop.uop_funct)
      VMANDN: logic_result = f_vmandn(alu_uop.vs2_data, alu_uop.vs1_data);
      VMAND:  logic_result = f_vmand(alu_uop.vs2_data, alu_uop.vs1_data);
      VMOR:   logic_result = f_vmor(alu_uop.vs2_data, alu_uop.vs1_data);
      VMXOR:  logic_result = f_vmxor(alu_uop.vs2_data, alu_uop.vs1_data);
      VMORN:  logic_result = f_vmorn(alu_uop.vs2_data, alu_uop.vs1_data);
      VMNAND: logic_result = f_vmnand(alu_uop.vs2_data, alu_uop.vs1_data);
      VMNOR:  logic_result = f_vmnor(alu_uop.vs2_data, alu_uop.vs1_data);
      VMXNOR: logic_result = f_vmxnor(alu_uop.vs2_data, alu_uop.vs1_data);
      default: begin
        assert (!alu_uop_valid)
          else $error("rob_entry=%0d unknown opcode %0h", alu_uop.rob_entry,
                      alu_uop.uop_funct);
      end
    endcase
  end

  // bits below vstart keep the old destination
  always_comb begin
    for (int i = 0; i < `VLEN; i++) begin
      if (i < int'(alu_uop.vstart)) begin
        w_data[i] = alu_uop.vd_data[i];
      end else begin
        w_data[i] = logic_result[i];
      end
    end
  end

  assign result_valid     = alu_uop_valid;
  assign result.rob_entry = alu_uop.rob_entry;
  assign result.w_data    = w_data;

endmodule

`default_nettype wire

// ==== src/rvv_pkg.sv ====
`default_nettype none

`include "rvv_settings.svh"

package rvv_pkg;

  // mask-register logical ops (OPMVV)
  typedef enum logic [2:0] {
    VMANDN,
    VMAND,
    VMOR,
    VMXOR,
    VMORN,
    VMNAND,
    VMNOR,
    VMXNOR
  } opm_funct_e;

  // uop as held in the ALU reservation station
  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    opm_funct_e                  uop_funct;
    logic [`VSTART_WIDTH-1:0]    vstart;
    // old destination, kept below vstart
    logic [`VLEN-1:0]            vd_data;
    logic [`VLEN-1:0]            vs1_data;
    logic [`VLEN-1:0]            vs2_data;
  } alu_rs_t;

  // ALU result written back into the ROB
  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [`VLEN-1:0]            w_data;
  } alu2rob_t;

endpackage

`default_nettype wire

// ==== src/rvv_rob.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_settings.svh"

module rvv_rob
  import rvv_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        result_valid,
  input  alu2rob_t                    result,
  input  logic                        commit_en,
  output logic                        retire_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0] retire_rob_entry,
  output logic [`VLEN-1:0]            retire_data
);

  logic [`VLEN-1:0]            data_mem [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0]       done;
  logic [`ROB_DEPTH_WIDTH-1:0] head;
  logic                        commit;

  // head retires only once its result is back
  assign commit = commit_en & done[head];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done         <= '0;
      head         <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= commit;
      if (commit) begin
        done[head] <= 1'b0;
        // wraps with the tag width
        head       <= head + 1'b1;
      end
      if (result_valid) begin
        done[result.rob_entry] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (result_valid) begin
      data_mem[result.rob_entry] <= result.w_data;
    end
    if (commit) begin
      retire_rob_entry <= head;
      retire_data      <= data_mem[head];
    end
  end

  // a tag is reused only after its previous owner retired
  a_no_overwrite_done: assert property (
    @(posedge clk) disable iff (!arst_n) result_valid |-> !done[result.rob_entry]
  ) else $error("result on busy ROB entry %0d", result.rob_entry);

endmodule

`default_nettype wire

// ==== src/rvv_settings.svh ====
`ifndef RVV_SETTINGS_SVH
`define RVV_SETTINGS_SVH

// vector register width in bits
`define VLEN 64

// reorder buffer, depth is a power of two
`define ROB_DEPTH 8
`define ROB_DEPTH_WIDTH 3

// reservation station, no shallower than the ROB
`define RS_DEPTH 8

// vstart must be able to count up to VLEN
`define VSTART_WIDTH 7

`endif

// ==== verification/tb_rvv_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_settings.svh"

module tb_rvv_alu_top
  import rvv_pkg::*;
();

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 16;
  localparam int N_RAND         = 64;
  localparam int N_BURST        = 3 * `ROB_DEPTH;
  localparam int HOLD_CYCLES    = 12;
  localparam int TOTAL_UOPS     = 8 + N_RAND + N_BURST + `ROB_DEPTH;
  localparam int CYCLES_PER_UOP = 16;
  localparam int WATCHDOG_NS    =
    (TOTAL_UOPS * CYCLES_PER_UOP + RESET_CYCLES + HOLD_CYCLES + 64) * CLK_PERIOD;

  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] tag;
    logic [`VLEN-1:0]            data;
  } exp_t;

  logic                        clk;
  logic                        arst_n;
  logic                        uop_valid;
  opm_funct_e                  uop_funct;
  logic [`VSTART_WIDTH-1:0]    uop_vstart;
  logic [`VLEN-1:0]            uop_vd;
  logic [`VLEN-1:0]            uop_vs1;
  logic [`VLEN-1:0]            uop_vs2;
  logic                        commit_en;
  logic                        dispatch_stall;
  logic                        retire_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] retire_rob_entry;
  logic [`VLEN-1:0]            retire_data;

  logic [31:0]                 lfsr = 32'h553e_b9d1;
  exp_t                        exp_q [$];
  logic                        exp_valid = 1'b0;
  logic [`ROB_DEPTH_WIDTH-1:0] exp_tag = '0;
  logic [`VLEN-1:0]            exp_data = '0;
  int                          issued = 0;
  int                          retired = 0;
  int                          err_cnt = 0;

  rvv_alu_top rvv_alu_top_i (
    .clk(clk), .arst_n(arst_n), .uop_valid(uop_valid), .uop_funct(uop_funct),
    .uop_vstart(uop_vstart), .uop_vd(uop_vd), .uop_vs1(uop_vs1), .uop_vs2(uop_vs2),
    .commit_en(commit_en), .dispatch_stall(dispatch_stall),
    .retire_valid(retire_valid), .retire_rob_entry(retire_rob_entry),
    .retire_data(retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [`VLEN-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr   = lfsr_next(lfsr);
      val[i] = lfsr[0];
    end
  endtask

  // reference: logic op on vs2/vs1, old vd kept below vstart
  function automatic logic [`VLEN-1:0] expect_mask_op(
      input opm_funct_e f, input logic [`VLEN-1:0] vs2, input logic [`VLEN-1:0] vs1,
      input logic [`VLEN-1:0] vd, input logic [`VSTART_WIDTH-1:0] vstart);
    logic [`VLEN-1:0] op;
    logic [`VLEN-1:0] keep;
    case (f)
      VMANDN:  op = vs2 & ~vs1;
      VMAND:   op = vs2 & vs1;
      VMOR:    op = vs2 | vs1;
      VMXOR:   op = vs2 ^ vs1;
      VMORN:   op = vs2 | ~vs1;
      VMNAND:  op = ~(vs2 & vs1);
      VMNOR:   op = ~(vs2 | vs1);
      default: op = ~(vs2 ^ vs1);
    endcase
    if (int'(vstart) >= `VLEN) keep = '1;
    else keep = (`VLEN'(1) << vstart) - `VLEN'(1);
    return (vd & keep) | (op & ~keep);
  endfunction

  // called at a falling edge, returns at a falling edge
  task automatic issue_uop(input opm_funct_e f, input logic [`VSTART_WIDTH-1:0] vs,
                           input logic [`VLEN-1:0] vd, input logic [`VLEN-1:0] vs1,
                           input logic [`VLEN-1:0] vs2, input bit rand_commit);
    exp_t             e;
    logic [`VLEN-1:0] b;
    if (rand_commit) begin
      take_bits(1, b);
      commit_en = b[0];
    end
    while (dispatch_stall) begin
      @(negedge clk);
      if (rand_commit) begin
        take_bits(1, b);
        commit_en = b[0];
      end
    end
    uop_valid  = 1'b1;
    uop_funct  = f;
    uop_vstart = vs;
    uop_vd     = vd;
    uop_vs1    = vs1;
    uop_vs2    = vs2;
    // tags count up from 0 and wrap at ROB depth
    e.tag  = `ROB_DEPTH_WIDTH'(issued % `ROB_DEPTH);
    e.data = expect_mask_op(f, vs2, vs1, vd, vs);
    exp_q.push_back(e);
    issued++;
    @(negedge clk);
    uop_valid = 1'b0;
  endtask

  task automatic issue_random_uop(input bit rand_commit);
    logic [`VLEN-1:0] fb;
    logic [`VLEN-1:0] sb;
    logic [`VLEN-1:0] vd;
    logic [`VLEN-1:0] vs1;
    logic [`VLEN-1:0] vs2;
    take_bits(3, fb);
    take_bits(`VSTART_WIDTH, sb);
    take_bits(`VLEN, vd);
    take_bits(`VLEN, vs1);
    take_bits(`VLEN, vs2);
    issue_uop(opm_funct_e'(fb[2:0]),
              `VSTART_WIDTH'(int'(sb[`VSTART_WIDTH-1:0]) % (`VLEN + 1)),
              vd, vs1, vs2, rand_commit);
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("drain timed out with %0d results outstanding", exp_q.size());
      err_cnt++;
    end
    // let the last retire be checked
    repeat (2) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s finished, %0d new errors", name, err_cnt - err_before);
  endtask

  // front of the expected queue lines up with the current retire pulse
  always @(negedge clk) begin
    if (arst_n && retire_valid) begin
      if (exp_q.size() != 0) begin
        exp_tag   = exp_q[0].tag;
        exp_data  = exp_q[0].data;
        exp_valid = 1'b1;
        void'(exp_q.pop_front());
      end else begin
        exp_valid = 1'b0;
      end
      retired++;
    end
  end

  a_retire_expected: assert property (
    @(posedge clk) disable iff (!arst_n) retire_valid |-> exp_valid
  ) else begin
    $display("retire of tag %0d with no uop outstanding", $sampled(retire_rob_entry));
    err_cnt++;
  end

  a_retire_tag: assert property (
    @(posedge clk) disable iff (!arst_n) retire_valid |-> (retire_rob_entry == exp_tag)
  ) else begin
    $display("Fail retire_rob_entry: got %h expected %h", $sampled(retire_rob_entry),
             $sampled(exp_tag));
    err_cnt++;
  end

  a_retire_data: assert property (
    @(posedge clk) disable iff (!arst_n) retire_valid |-> (retire_data == exp_data)
  ) else begin
    $display("Fail retire_data: got %h expected %h", $sampled(retire_data),
             $sampled(exp_data));
    err_cnt++;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int               e0;
    int               stall_issued;
    logic [`VLEN-1:0] vd;
    logic [`VLEN-1:0] vs1;
    logic [`VLEN-1:0] vs2;
    logic [`VLEN-1:0] b;
    arst_n     = 1'b0;
    uop_valid  = 1'b0;
    uop_funct  = VMANDN;
    uop_vstart = '0;
    uop_vd     = '0;
    uop_vs1    = '0;
    uop_vs2    = '0;
    commit_en  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    e0 = err_cnt;
    assert (!retire_valid && !dispatch_stall) else begin
      $display("Fail retire_valid/dispatch_stall: got %h/%h expected 0/0",
               retire_valid, dispatch_stall);
      err_cnt++;
    end
    report_test("reset", e0);

    // every opcode once, vstart 0
    e0 = err_cnt;
    commit_en = 1'b1;
    for (int k = 0; k < 8; k++) begin
      take_bits(`VLEN, vd);
      take_bits(`VLEN, vs1);
      take_bits(`VLEN, vs2);
      issue_uop(opm_funct_e'(3'(k)), '0, vd, vs1, vs2, 1'b0);
    end
    wait_drain(64);
    report_test("opcodes", e0);

    // random vstart, gaps and commit_en
    e0 = err_cnt;
    for (int k = 0; k < N_RAND; k++) begin
      take_bits(1, b);
      if (!b[0]) @(negedge clk);
      issue_random_uop(1'b1);
    end
    commit_en = 1'b1;
    wait_drain(N_RAND * CYCLES_PER_UOP);
    report_test("random_vstart", e0);

    // back to back, tags wrap a few times
    e0 = err_cnt;
    for (int k = 0; k < N_BURST; k++) begin
      issue_random_uop(1'b0);
    end
    wait_drain(N_BURST * CYCLES_PER_UOP);
    report_test("tag_order", e0);

    // fill the ROB with commit held off
    e0 = err_cnt;
    commit_en    = 1'b0;
    stall_issued = 0;
    while (!dispatch_stall && stall_issued < 2 * `ROB_DEPTH) begin
      issue_random_uop(1'b0);
      stall_issued++;
    end
    assert (stall_issued == `ROB_DEPTH) else begin
      $display("Fail issued_before_stall: got %h expected %h", stall_issued, `ROB_DEPTH);
      err_cnt++;
    end
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      assert (dispatch_stall && !retire_valid) else begin
        $display("stall dropped or a uop retired while commit_en was low");
        err_cnt++;
      end
    end
    commit_en = 1'b1;
    wait_drain(`ROB_DEPTH * CYCLES_PER_UOP);
    report_test("backpressure", e0);

    assert (retired == issued && exp_q.size() == 0) else begin
      $display("results lost or duplicated: issued %0d, retired %0d", issued, retired);
      err_cnt++;
    end
    $display("summary: issued %0d, retired %0d, errors %0d", issued, retired, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
